// ==== sources.f ====
// CORDIC subsystem, compile order
+incdir+logic
logic/cordic_pkg.sv
logic/cordic_rotator.sv
logic/cordic_stream_if.sv
logic/cordic_cfg_regs.sv
logic/cordic_top.sv
// Testbench
tests/cordic_tb.sv

// ==== Makefile ====
# Verilator build, run and lint of the CORDIC subsystem
# Pass or fail comes from the pass message in the run log

TOP := cordic_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 -f sources.f \
		--top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	verilator --lint-only --timing --assert -f sources.f \
		--top-module cordic_top

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/cordic_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for cordic_top
// Random angles from a fixed seed, checked against an integer CORDIC
// model kept here; outputs are read on the falling clock edge
// Stops at the first mismatch, a watchdog bounds the run
//////////////////////////////////////////////////////////////////////

`include "cordic_cfg.svh"

module cordic_tb;

  localparam int  W        = `CORDIC_DATA_W;
  localparam int  STAGES   = `CORDIC_STAGES;
  localparam int  LATENCY  = STAGES + 2;
  // Latency from the drive edge plus the negedge where results are read
  localparam int  ARRIVE   = LATENCY + 1;
  localparam int  SEED     = 23366;
  localparam int  N_BURST  = 500;
  localparam int  N_EDGE   = 16;
  localparam int  N_OFFSET = 300;
  localparam int  N_RESUME = 100;
  localparam int  N_GAP    = 400;
  localparam real PI_R     = 3.14159265358979323846;
  // Cycle budget over samples, drains, config writes and reset
  localparam int  BUDGET   = N_BURST + N_EDGE + N_OFFSET + LATENCY + N_RESUME + N_GAP
                           + 8 * (ARRIVE + 2) + 4 * 6 + 5;
  localparam int  TIMEOUT  = 2 * 4 * BUDGET + 200;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  cordic_pkg::angle_t    in_angle;
  cordic_pkg::tag_t      in_tag;
  logic                  out_valid;
  cordic_pkg::sample_t   out_sin;
  cordic_pkg::sample_t   out_cos;
  cordic_pkg::tag_t      out_tag;
  logic                  cfg_req;
  cordic_pkg::cfg_addr_t cfg_addr;
  cordic_pkg::angle_t    cfg_wdata;
  logic                  cfg_ack;

  // Model copy of the config registers
  cordic_pkg::angle_t    mdl_offset;
  logic                  mdl_enable;

  // Expected results with their arrival negedge
  int                    exp_cycle [$];
  cordic_pkg::sample_t   exp_sin [$];
  cordic_pkg::sample_t   exp_cos [$];
  cordic_pkg::tag_t      exp_tag [$];

  int                    cycle = 0;
  bit                    checking = 1'b0;

  cordic_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_angle  (in_angle),
    .in_tag    (in_tag),
    .out_valid (out_valid),
    .out_sin   (out_sin),
    .out_cos   (out_cos),
    .out_tag   (out_tag),
    .cfg_req   (cfg_req),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_ack   (cfg_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic compare_sample(input string name, input cordic_pkg::sample_t got,
                                input cordic_pkg::sample_t exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "sample mismatch");
    end
  endtask

  task automatic compare_tag(input string name, input cordic_pkg::tag_t got,
                             input cordic_pkg::tag_t exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s = %0h, expected %0h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "tag mismatch");
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s = %b, expected %b", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "flag mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Sign-extend the low W bits as a W-bit register holds them
  function automatic int wrap_word(input int v);
    cordic_pkg::angle_t t;
    t = cordic_pkg::angle_t'(v);
    return int'(t);
  endfunction

  // round(atan(2^-i) * 2^(W-1) / pi)
  function automatic int atan_ref(input int stage);
    real r;
    r = $atan(1.0 / (2.0 ** stage)) * (2.0 ** (W - 1)) / PI_R;
    return int'(r);
  endfunction

  function automatic void cordic_model(input cordic_pkg::angle_t angle,
                                       input cordic_pkg::angle_t offset,
                                       output cordic_pkg::sample_t sin_o,
                                       output cordic_pkg::sample_t cos_o);
    cordic_pkg::angle_t sum;
    logic               fold;
    int                 x;
    int                 y;
    int                 z;
    int                 xn;
    int                 yn;
    int                 zn;
    sum  = cordic_pkg::angle_t'(int'(angle) + int'(offset));
    // Outside +-pi/2 rotate by pi and negate afterwards
    fold = sum[W-1] ^ sum[W-2];
    z    = fold ? wrap_word(int'(sum) - (1 << (W - 1))) : int'(sum);
    x    = int'(0.607253 * (2.0 ** (W - 2)));
    y    = 0;
    for (int i = 0; i < STAGES; i++) begin
      if (z < 0) begin
        xn = x + (y >>> i);
        yn = y - (x >>> i);
        zn = z + atan_ref(i);
      end else begin
        xn = x - (y >>> i);
        yn = y + (x >>> i);
        zn = z - atan_ref(i);
      end
      x = wrap_word(xn);
      y = wrap_word(yn);
      z = wrap_word(zn);
    end
    sin_o = fold ? cordic_pkg::sample_t'(-y) : cordic_pkg::sample_t'(y);
    cos_o = fold ? cordic_pkg::sample_t'(-x) : cordic_pkg::sample_t'(x);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////
  task automatic drive_sample(input logic valid, input cordic_pkg::angle_t angle,
                              input cordic_pkg::tag_t tag);
    cordic_pkg::sample_t s;
    cordic_pkg::sample_t c;
    @(posedge clk);
    in_valid <= valid;
    in_angle <= angle;
    in_tag   <= tag;
    // Disabled samples never come out
    if (valid && mdl_enable) begin
      cordic_model(angle, mdl_offset, s, c);
      exp_cycle.push_back(cycle + ARRIVE);
      exp_sin.push_back(s);
      exp_cos.push_back(c);
      exp_tag.push_back(tag);
    end
  endtask

  task automatic drive_random(input logic valid);
    cordic_pkg::angle_t a;
    cordic_pkg::tag_t   t;
    a = cordic_pkg::angle_t'($urandom);
    t = cordic_pkg::tag_t'($urandom);
    drive_sample(valid, a, t);
  endtask

  // Quadrant edges including +-pi/2 and the most negative angle
  function automatic cordic_pkg::angle_t edge_angle(input int k);
    int q;
    int v;
    q = 1 << (W - 2);
    case (k)
      0:       v = 0;
      1:       v = q;
      2:       v = -q;
      3:       v = -2 * q;
      4:       v = 2 * q - 1;
      5:       v = q - 1;
      6:       v = q + 1;
      7:       v = -q + 1;
      8:       v = -q - 1;
      9:       v = 1;
      10:      v = -1;
      11:      v = q / 2;
      12:      v = 3 * q / 2;
      13:      v = -q / 2;
      14:      v = -3 * q / 2;
      default: v = -2 * q + 1;
    endcase
    return cordic_pkg::angle_t'(v);
  endfunction

  // Four-phase write with ack one cycle behind req each way
  task automatic cfg_write(input cordic_pkg::cfg_addr_t addr,
                           input cordic_pkg::angle_t data);
    @(posedge clk);
    in_valid  <= 1'b0;
    cfg_req   <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(negedge clk);
    compare_flag("cfg_ack", cfg_ack, 1'b0);
    @(negedge clk);
    compare_flag("cfg_ack", cfg_ack, 1'b1);
    @(posedge clk);
    cfg_req <= 1'b0;
    @(negedge clk);
    compare_flag("cfg_ack", cfg_ack, 1'b1);
    @(negedge clk);
    compare_flag("cfg_ack", cfg_ack, 1'b0);
    if (addr == cordic_pkg::cfg_addr_t'(0)) begin
      mdl_offset = data;
    end else begin
      mdl_enable = data[0];
    end
  endtask

  // Stop the stream and let every expected result come out
  task automatic drain;
    @(posedge clk);
    in_valid <= 1'b0;
    while (exp_cycle.size() != 0) begin
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    cycle = cycle + 1;
    if (checking) begin
      if (exp_cycle.size() != 0 && exp_cycle[0] == cycle) begin
        compare_flag("out_valid", out_valid, 1'b1);
        compare_sample("out_sin", out_sin, exp_sin[0]);
        compare_sample("out_cos", out_cos, exp_cos[0]);
        compare_tag("out_tag", out_tag, exp_tag[0]);
        void'(exp_cycle.pop_front());
        void'(exp_sin.pop_front());
        void'(exp_cos.pop_front());
        void'(exp_tag.pop_front());
      end else begin
        // Idle output carries zero data
        compare_flag("out_valid", out_valid, 1'b0);
        compare_sample("out_sin", out_sin, '0);
        compare_sample("out_cos", out_cos, '0);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_angle   = '0;
    in_tag     = '0;
    cfg_req    = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    mdl_offset = '0;
    mdl_enable = 1'b1;
    repeat (5) @(posedge clk);
    rst_n    <= 1'b1;
    checking = 1'b1;
    @(negedge clk);
    compare_flag("cfg_ack", cfg_ack, 1'b0);

    // Back-to-back burst at zero offset
    repeat (N_BURST) drive_random(1'b1);
    drain();

    // Quadrant edges and fold
    for (int k = 0; k < N_EDGE; k++) begin
      drive_sample(1'b1, edge_angle(k), cordic_pkg::tag_t'(k));
    end
    drain();

    // Random phase offset
    cfg_write(1'b0, cordic_pkg::angle_t'($urandom));
    repeat (N_OFFSET) drive_random(1'b1);
    drain();

    // Disabled stream gives nothing out for a full latency
    cfg_write(1'b1, cordic_pkg::angle_t'(0));
    repeat (LATENCY) drive_random(1'b1);
    repeat (ARRIVE) drive_random(1'b0);
    cfg_write(1'b1, cordic_pkg::angle_t'(1));
    repeat (N_RESUME) drive_random(1'b1);
    drain();

    // Random gaps in the input
    repeat (N_GAP) drive_random(($urandom % 3) != 0);
    drain();

    if (exp_cycle.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Expected results still pending at the end of the run");
      $display("Test failures found");
      $fatal(1, "pending results");
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Watchdog expired after %0d time units", TIMEOUT);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== logic/cordic_top.sv ====
//////////////////////////////////////////////////////////////////////
// CORDIC sine and cosine generator, top level
// Sample in with in_valid, sin and cos out CORDIC_STAGES + 2 cycles
// later with the same tag. No back-pressure
// Phase offset and enable are written over the cfg_req/cfg_ack port
//////////////////////////////////////////////////////////////////////

module cordic_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // Sample stream in
  input  logic                  in_valid,
  input  cordic_pkg::angle_t    in_angle,
  input  cordic_pkg::tag_t      in_tag,
  // Result stream out
  output logic                  out_valid,
  output cordic_pkg::sample_t   out_sin,
  output cordic_pkg::sample_t   out_cos,
  output cordic_pkg::tag_t      out_tag,
  // Configuration write port
  input  logic                  cfg_req,
  input  cordic_pkg::cfg_addr_t cfg_addr,
  input  cordic_pkg::angle_t    cfg_wdata,
  output logic                  cfg_ack
);

  // Register block to stream block
  cordic_pkg::angle_t phase_offset;
  logic               enable;

  cordic_cfg_regs u_cfg_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_req      (cfg_req),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_ack      (cfg_ack),
    .phase_offset (phase_offset),
    .enable       (enable)
  );

  cordic_stream_if u_stream_if (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_angle     (in_angle),
    .in_tag       (in_tag),
    .phase_offset (phase_offset),
    .enable       (enable),
    .out_valid    (out_valid),
    .out_sin      (out_sin),
    .out_cos      (out_cos),
    .out_tag      (out_tag)
  );

endmodule

// ==== logic/cordic_cfg_regs.sv ====
//////////////////////////////////////////////////////////////////////
// Configuration registers on a four-phase req/ack write port
// Address 0 is the phase offset, address 1 is control (bit 0 enable)
// The host holds addr and wdata stable while req is high and
// raises req again only once ack is low. No readback
//////////////////////////////////////////////////////////////////////

module cordic_cfg_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cfg_req,
  input  cordic_pkg::cfg_addr_t cfg_addr,
  input  cordic_pkg::angle_t    cfg_wdata,
  output logic                  cfg_ack,
  output cordic_pkg::angle_t    phase_offset,
  output logic                  enable
);

  // Handshake phases
  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } hs_state_t;

  hs_state_t state_q;

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM and register writes
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      phase_offset <= '0;
      enable       <= 1'b1;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // Request seen so write once and raise ack
          if (cfg_req) begin
            state_q <= ST_ACK;
            if (cfg_addr == cordic_pkg::cfg_addr_t'(0)) begin
              phase_offset <= cfg_wdata;
            end else begin
              enable <= cfg_wdata[0];
            end
          end
        end
        ST_ACK: begin
          // Wait for the host to drop req
          if (!cfg_req) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Ack is the FSM phase itself
  assign cfg_ack = (state_q == ST_ACK);

  // Ack never rises while req is low
  a_ack_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cfg_ack) |-> cfg_req);

  // Host starts a new cycle only after ack is back low
  a_req_after_ack : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cfg_req) |-> !cfg_ack);

endmodule

// ==== logic/cordic_stream_if.sv ====
//////////////////////////////////////////////////////////////////////
// Streaming wrapper around the CORDIC rotator
// Adds the phase offset, folds the angle into -pi/2 .. +pi/2 and
// undoes the fold on the results
// Latency is CORDIC_STAGES + 2 cycles, no back-pressure, the output
// must be taken whenever out_valid is high
//////////////////////////////////////////////////////////////////////

`include "cordic_cfg.svh"

module cordic_stream_if (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  cordic_pkg::angle_t  in_angle,
  input  cordic_pkg::tag_t    in_tag,
  input  cordic_pkg::angle_t  phase_offset,
  input  logic                enable,
  output logic                out_valid,
  output cordic_pkg::sample_t out_sin,
  output cordic_pkg::sample_t out_cos,
  output cordic_pkg::tag_t    out_tag
);

  localparam int STAGES = `CORDIC_STAGES;
  localparam int MSB    = `CORDIC_DATA_W - 1;

  // Half a turn, i.e. pi
  localparam cordic_pkg::angle_t HALF_TURN = {1'b1, {MSB{1'b0}}};

  cordic_pkg::angle_t  sum_c;
  cordic_pkg::angle_t  angle_c;
  logic                fold_c;

  // Input register
  logic                valid_q;
  cordic_pkg::angle_t  angle_q;
  cordic_pkg::tag_t    tag_q;
  logic                fold_q;

  // Side band shift line matching the rotator depth
  logic [STAGES-1:0]   valid_line;
  logic [STAGES-1:0]   fold_line;
  cordic_pkg::tag_t    tag_line [0:STAGES-1];

  cordic_pkg::sample_t raw_sin;
  cordic_pkg::sample_t raw_cos;

  //////////////////////////////////////////////////////////////////////
  // Offset and quadrant fold
  //////////////////////////////////////////////////////////////////////

  // Wraps modulo a full turn
  assign sum_c   = in_angle + phase_offset;
  // Top bits differ means outside +-pi/2
  assign fold_c  = sum_c[MSB] ^ sum_c[MSB-1];
  assign angle_c = fold_c ? sum_c - HALF_TURN : sum_c;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= 1'b0;
      valid_line <= '0;
    end else begin
      // Disabled samples are dropped here
      valid_q    <= in_valid & enable;
      valid_line <= {valid_line[STAGES-2:0], valid_q};
    end
  end

  always_ff @(posedge clk) begin
    angle_q      <= angle_c;
    tag_q        <= in_tag;
    fold_q       <= fold_c;
    tag_line[0]  <= tag_q;
    fold_line[0] <= fold_q;
    for (int i = 1; i < STAGES; i++) begin
      tag_line[i]  <= tag_line[i-1];
      fold_line[i] <= fold_line[i-1];
    end
  end

  cordic_rotator u_rotator (
    .clk     (clk),
    .rst_n   (rst_n),
    .angle   (angle_q),
    .raw_sin (raw_sin),
    .raw_cos (raw_cos)
  );

  //////////////////////////////////////////////////////////////////////
  // Un-fold and output register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_sin   <= '0;
      out_cos   <= '0;
    end else begin
      out_valid <= valid_line[STAGES-1];
      if (!valid_line[STAGES-1]) begin
        // Idle data stays at zero
        out_sin <= '0;
        out_cos <= '0;
      end else if (fold_line[STAGES-1]) begin
        // Rotation by pi negates both results
        out_sin <= -raw_sin;
        out_cos <= -raw_cos;
      end else begin
        out_sin <= raw_sin;
        out_cos <= raw_cos;
      end
    end
  end

  always_ff @(posedge clk) begin
    out_tag <= tag_line[STAGES-1];
  end

  // Tag must have travelled the whole line with its sample
  a_tag_known : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(out_tag));

endmodule

// ==== logic/cordic_rotator.sv ====
//////////////////////////////////////////////////////////////////////
// Rotation-mode CORDIC pipeline, one register per stage
// Latency is CORDIC_STAGES cycles, a new angle may enter every cycle
// The input angle must already lie within -pi/2 .. +pi/2, the
// caller folds it into that range
//////////////////////////////////////////////////////////////////////

`include "cordic_cfg.svh"

module cordic_rotator (
  input  logic                clk,
  input  logic                rst_n,
  input  cordic_pkg::angle_t  angle,
  output cordic_pkg::sample_t raw_sin,
  output cordic_pkg::sample_t raw_cos
);

  localparam int STAGES = `CORDIC_STAGES;
  localparam int MSB    = `CORDIC_DATA_W - 1;

  // Elaboration check on the stage count
  if (STAGES > `CORDIC_DATA_W - 2) begin : g_bad_stages
    $error("CORDIC_STAGES exceeds CORDIC_DATA_W - 2");
  end

  // Stage output registers
  cordic_pkg::sample_t x_q [0:STAGES-1];
  cordic_pkg::sample_t y_q [0:STAGES-1];
  cordic_pkg::angle_t  z_q [0:STAGES-1];

  //////////////////////////////////////////////////////////////////////
  // Micro-rotation stages
  //////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < STAGES; i++) begin : g_stage

    // Per-stage arctangent constant
    localparam cordic_pkg::angle_t ATAN_C = cordic_pkg::atan_entry(i);

    cordic_pkg::sample_t x_in;
    cordic_pkg::sample_t y_in;
    cordic_pkg::angle_t  z_in;
    cordic_pkg::sample_t x_sh;
    cordic_pkg::sample_t y_sh;
    logic                z_neg;

    // Stage 0 starts on the x axis at 1/K, later stages chain on
    if (i == 0) begin : g_first
      assign x_in = cordic_pkg::CORDIC_GAIN_INIT;
      assign y_in = '0;
      assign z_in = angle;
    end else begin : g_next
      assign x_in = x_q[i-1];
      assign y_in = y_q[i-1];
      assign z_in = z_q[i-1];
    end

    // Arithmetic shifts keep the sign
    assign x_sh  = x_in >>> i;
    assign y_sh  = y_in >>> i;

    // d = -1 only for a strictly negative residual angle
    assign z_neg = z_in[MSB];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        x_q[i] <= '0;
        y_q[i] <= '0;
        z_q[i] <= '0;
      end else if (z_neg) begin
        // Rotate clockwise
        x_q[i] <= x_in + y_sh;
        y_q[i] <= y_in - x_sh;
        z_q[i] <= z_in + ATAN_C;
      end else begin
        // Rotate counter-clockwise
        x_q[i] <= x_in - y_sh;
        y_q[i] <= y_in + x_sh;
        z_q[i] <= z_in - ATAN_C;
      end
    end

  end

  // Final vector, y is sine and x is cosine
  assign raw_sin = y_q[STAGES-1];
  assign raw_cos = x_q[STAGES-1];

endmodule

// ==== logic/cordic_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types and constants of the CORDIC subsystem
// Angles are binary, a full turn spans the whole word, half scale = pi
// Results are signed with two integer bits (1.0 = 2^(DATA_W-2))
// The arctangent table is built at elaboration from real math
//////////////////////////////////////////////////////////////////////

`include "cordic_cfg.svh"

package cordic_pkg;

  // Signed binary angle, wraps modulo a full turn
  typedef logic signed [`CORDIC_DATA_W-1:0] angle_t;

  // Signed sine or cosine sample
  typedef logic signed [`CORDIC_DATA_W-1:0] sample_t;

  // Stream ID carried alongside each sample
  typedef logic [`CORDIC_ID_W-1:0] tag_t;

  // Register address, 0 = phase offset, 1 = control
  typedef logic cfg_addr_t;

  localparam real PI = 3.14159265358979323846;

  // Start value of x, pre-scaled by 1/K so the outputs land at unit gain
  localparam sample_t CORDIC_GAIN_INIT =
    sample_t'(int'(0.607253 * (2.0 ** (`CORDIC_DATA_W - 2))));

  //////////////////////////////////////////////////////////////////////
  // Arctangent table entry for stage i, in binary angle units
  //////////////////////////////////////////////////////////////////////
  function automatic angle_t atan_entry(input int stage);
    real scale;
    real rad;
    scale = 2.0 ** (`CORDIC_DATA_W - 1);
    rad   = $atan(1.0 / (2.0 ** stage));
    // Cast from real rounds to nearest
    return angle_t'(int'(rad * scale / PI));
  endfunction

endpackage

// ==== logic/cordic_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// Build-time sizes of the CORDIC subsystem
// CORDIC_STAGES must stay at or below CORDIC_DATA_W - 2, otherwise
// the last shifts and arctangent entries collapse to zero
//////////////////////////////////////////////////////////////////////

`ifndef CORDIC_CFG_SVH
`define CORDIC_CFG_SVH

// Angle and result word width
`define CORDIC_DATA_W 16

// Stream ID tag width
`define CORDIC_ID_W 4

// Rotation stages, one register each
`define CORDIC_STAGES 14

`endif
